/* src/vision_ctrl_pkg.sv */
// Shared types and constants for the camera control front end.
// Holds the pipeline control struct, the register write struct and the
// fixed camera register table played by the configuration sequencer.
package vision_ctrl_pkg;

	// Pipeline operating mode
	typedef enum logic {
		MODE_PASSTHROUGH = 1'b0,
		MODE_FILTER      = 1'b1
	} mode_e;

	// One-shot configuration start
	typedef enum logic {
		CTRL_CFG    = 1'b0,
		CTRL_ACTIVE = 1'b1
	} ctrl_state_e;

	// Flush sequencer, released on start of frame
	typedef enum logic {
		FLUSH_IDLE   = 1'b0,
		FLUSH_ACTIVE = 1'b1
	} flush_state_e;

	typedef struct packed {
		mode_e mode;
		logic  gaussian_en;
		logic  sobel_en;
		logic  flush;
	} pipe_ctrl_t;

	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
	} cfg_write_t;

	// ============================================================
	// Camera register table
	// ============================================================
	localparam int CFG_ROM_DEPTH = 8;
	localparam int CFG_IDX_W     = $clog2(CFG_ROM_DEPTH);

	// Soft reset first, then RGB565 output at full clock
	localparam cfg_write_t CFG_ROM [0:CFG_ROM_DEPTH-1] = '{
		'{addr: 8'h12, data: 8'h80},
		'{addr: 8'h12, data: 8'h04},
		'{addr: 8'h11, data: 8'h80},
		'{addr: 8'h0c, data: 8'h00},
		'{addr: 8'h3e, data: 8'h00},
		'{addr: 8'h40, data: 8'hd0},
		'{addr: 8'h8c, data: 8'h00},
		'{addr: 8'h3a, data: 8'h04}
	};

	localparam int FRAME_CNT_W = 16;

endpackage

/* src/debounce.sv */
// Counter debouncer for one mechanical input such as a push-button.
// The output follows the input once it has held steady for DB_COUNT cycles.
`timescale 1ns/100ps

module debounce #(
	parameter int DB_COUNT = 500000
) (
	input  logic i_sysclk,
	input  logic i_rstn,
	input  logic i_input,
	output logic o_db
);

	logic                          in_q1;
	logic                          in_q2;
	logic [$clog2(DB_COUNT+1)-1:0] cnt;

	// Two-flop synchronizer
	always_ff @(posedge i_sysclk) begin
		if (!i_rstn) begin
			in_q1 <= 1'b0;
			in_q2 <= 1'b0;
		end else begin
			in_q1 <= i_input;
			in_q2 <= in_q1;
		end
	end

	// Count cycles of disagreement, any agreement restarts
	always_ff @(posedge i_sysclk) begin
		if (!i_rstn) begin
			cnt  <= '0;
			o_db <= 1'b0;
		end else if (in_q2 == o_db) begin
			cnt <= '0;
		end else if (cnt == DB_COUNT) begin
			cnt  <= '0;
			o_db <= in_q2;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	a_db_change_after_count: assert property (@(posedge i_sysclk) disable iff (!i_rstn)
		$changed(o_db) |-> $past(cnt) == DB_COUNT);

endmodule

/* src/sys_control.sv */
// Board input controller for the video pipeline.
// Toggles passthrough/filter mode on a debounced button press, drives the
// filter enables, flushes the pipeline on switch changes and kicks off
// the camera configuration once after reset.
`timescale 1ns/100ps

module sys_control
	import vision_ctrl_pkg::*;
(
	input  logic       i_sysclk,
	input  logic       i_rstn,
	input  logic       i_sof,
	input  logic       i_btn_db,
	input  logic       i_sw_gaussian,
	input  logic       i_sw_sobel,
	output logic       o_cfg_start,
	output pipe_ctrl_t o_pipe_ctrl
);

	// ============================================================
	// Declarations
	// ============================================================
	ctrl_state_e  ctrl_state;
	mode_e        mode;
	mode_e        mode_nxt;
	flush_state_e flush_state;

	logic         btn_q1;
	logic         btn_q2;
	logic         btn_rise;

	// Bit 1 is gaussian, bit 0 is sobel
	logic [1:0]   sw_q1;
	logic [1:0]   sw_q2;
	logic         sw_delta;

	logic         gaussian_en;
	logic         sobel_en;

	// ============================================================
	// Configuration kick-off
	// ============================================================
	always_ff @(posedge i_sysclk) begin
		if (!i_rstn) begin
			ctrl_state  <= CTRL_CFG;
			o_cfg_start <= 1'b0;
		end else begin
			case (ctrl_state)
				CTRL_CFG: begin
					o_cfg_start <= 1'b1;
					ctrl_state  <= CTRL_ACTIVE;
				end
				default: begin
					o_cfg_start <= 1'b0;
				end
			endcase
		end
	end

	// ============================================================
	// Mode toggle
	// ============================================================
	always_ff @(posedge i_sysclk) begin
		if (!i_rstn) begin
			btn_q1 <= 1'b0;
			btn_q2 <= 1'b0;
		end else begin
			btn_q1 <= i_btn_db;
			btn_q2 <= btn_q1;
		end
	end

	assign btn_rise = btn_q1 & ~btn_q2;

	// Enables and flush look at the upcoming mode so they never lag it
	always_comb begin
		mode_nxt = mode;
		if (btn_rise) begin
			mode_nxt = (mode == MODE_FILTER) ? MODE_PASSTHROUGH : MODE_FILTER;
		end
	end

	always_ff @(posedge i_sysclk) begin
		if (!i_rstn) begin
			mode <= MODE_PASSTHROUGH;
		end else begin
			mode <= mode_nxt;
		end
	end

	// ============================================================
	// Switch delays and filter enables
	// ============================================================
	always_ff @(posedge i_sysclk) begin
		if (!i_rstn) begin
			sw_q1 <= 2'b00;
			sw_q2 <= 2'b00;
		end else begin
			sw_q1 <= {i_sw_gaussian, i_sw_sobel};
			sw_q2 <= sw_q1;
		end
	end

	assign sw_delta = |(sw_q1 ^ sw_q2);

	always_ff @(posedge i_sysclk) begin
		if (!i_rstn || mode_nxt == MODE_PASSTHROUGH) begin
			gaussian_en <= 1'b0;
			sobel_en    <= 1'b0;
		end else begin
			gaussian_en <= sw_q1[1];
			sobel_en    <= sw_q1[0];
		end
	end

	// ============================================================
	// Flush sequencer
	// ============================================================
	// Held from a switch change until the next start of frame
	always_ff @(posedge i_sysclk) begin
		if (!i_rstn || mode_nxt == MODE_PASSTHROUGH) begin
			flush_state <= FLUSH_IDLE;
		end else begin
			case (flush_state)
				FLUSH_IDLE: begin
					if (sw_delta) flush_state <= FLUSH_ACTIVE;
				end
				default: begin
					if (i_sof) flush_state <= FLUSH_IDLE;
				end
			endcase
		end
	end

	assign o_pipe_ctrl = '{
		mode:        mode,
		gaussian_en: gaussian_en,
		sobel_en:    sobel_en,
		flush:       (flush_state == FLUSH_ACTIVE)
	};

	a_no_flush_passthrough: assert property (@(posedge i_sysclk) disable iff (!i_rstn)
		o_pipe_ctrl.flush |-> o_pipe_ctrl.mode == MODE_FILTER);

	a_no_en_passthrough: assert property (@(posedge i_sysclk) disable iff (!i_rstn)
		o_pipe_ctrl.mode == MODE_PASSTHROUGH |->
			!o_pipe_ctrl.gaussian_en && !o_pipe_ctrl.sobel_en);

	a_cfg_start_single: assert property (@(posedge i_sysclk) disable iff (!i_rstn)
		o_cfg_start |=> !o_cfg_start);

endmodule

/* src/cam_config.sv */
// Camera register sequencer.
// On a start pulse it plays the fixed register table as one write strobe
// per cycle, then raises a done level until the next start.
`timescale 1ns/100ps

module cam_config
	import vision_ctrl_pkg::*;
(
	input  logic       i_sysclk,
	input  logic       i_rstn,
	input  logic       i_cfg_start,
	output logic       o_cfg_wr,
	output cfg_write_t o_cfg,
	output logic       o_cfg_done
);

	// ============================================================
	// Declarations
	// ============================================================
	logic                 busy;
	// Index of the entry currently on o_cfg
	logic [CFG_IDX_W-1:0] idx;
	logic [CFG_IDX_W-1:0] idx_nxt;
	logic                 last_entry;

	assign idx_nxt    = idx + 1'b1;
	assign last_entry = (idx == CFG_IDX_W'(CFG_ROM_DEPTH - 1));

	// ============================================================
	// Sequencer control
	// ============================================================
	always_ff @(posedge i_sysclk) begin
		if (!i_rstn) begin
			busy       <= 1'b0;
			idx        <= '0;
			o_cfg_wr   <= 1'b0;
			o_cfg_done <= 1'b0;
		end else if (!busy) begin
			// A start while busy falls through to the branch below
			if (i_cfg_start) begin
				busy       <= 1'b1;
				idx        <= '0;
				o_cfg_wr   <= 1'b1;
				o_cfg_done <= 1'b0;
			end
		end else if (last_entry) begin
			busy       <= 1'b0;
			o_cfg_wr   <= 1'b0;
			o_cfg_done <= 1'b1;
		end else begin
			idx      <= idx_nxt;
			o_cfg_wr <= 1'b1;
		end
	end

	// ============================================================
	// Write payload
	// ============================================================
	// Only meaningful while o_cfg_wr is high
	always_ff @(posedge i_sysclk) begin
		if (!busy) begin
			if (i_cfg_start) begin
				o_cfg <= CFG_ROM[0];
			end
		end else if (!last_entry) begin
			o_cfg <= CFG_ROM[idx_nxt];
		end
	end

	a_wr_only_busy: assert property (@(posedge i_sysclk) disable iff (!i_rstn)
		o_cfg_wr |-> busy);

endmodule

/* src/frame_sync.sv */
// Camera frame synchronizer.
// Brings vsync into the system clock domain, emits a one-cycle start of
// frame pulse on each rising edge and keeps a wrapping frame count.
`timescale 1ns/100ps

module frame_sync
	import vision_ctrl_pkg::*;
(
	input  logic                   i_sysclk,
	input  logic                   i_rstn,
	input  logic                   i_vsync,
	output logic                   o_sof,
	output logic [FRAME_CNT_W-1:0] o_frame_count
);

	logic vs_q1;
	logic vs_q2;
	// Previous synchronized value for edge detection
	logic vs_q3;
	logic vs_rise;

	always_ff @(posedge i_sysclk) begin
		if (!i_rstn) begin
			vs_q1 <= 1'b0;
			vs_q2 <= 1'b0;
			vs_q3 <= 1'b0;
		end else begin
			vs_q1 <= i_vsync;
			vs_q2 <= vs_q1;
			vs_q3 <= vs_q2;
		end
	end

	assign vs_rise = vs_q2 & ~vs_q3;

	// Pulse and count update together
	always_ff @(posedge i_sysclk) begin
		if (!i_rstn) begin
			o_sof         <= 1'b0;
			o_frame_count <= '0;
		end else begin
			o_sof <= vs_rise;
			if (vs_rise) o_frame_count <= o_frame_count + 1'b1;
		end
	end

endmodule

/* src/vision_ctrl_top.sv */
// Top level of the camera pipeline control front end.
// Wires the button debouncer, the mode controller, the camera register
// sequencer and the frame synchronizer together.
`timescale 1ns/100ps

module vision_ctrl_top
	import vision_ctrl_pkg::*;
#(
	// 20 ms at 25 MHz
	parameter int DB_COUNT = 500000
) (
	input  logic                   i_sysclk,
	input  logic                   i_rstn,
	input  logic                   i_btn_mode,
	input  logic                   i_sw_gaussian,
	input  logic                   i_sw_sobel,
	input  logic                   i_vsync,
	output pipe_ctrl_t             o_pipe_ctrl,
	output logic                   o_cfg_wr,
	output cfg_write_t             o_cfg,
	output logic                   o_cfg_done,
	output logic [FRAME_CNT_W-1:0] o_frame_count
);

	logic btn_db;
	logic sof;
	logic cfg_start;

	debounce #(.DB_COUNT(DB_COUNT)) db_mode_i (
		.i_sysclk (i_sysclk),
		.i_rstn   (i_rstn),
		.i_input  (i_btn_mode),
		.o_db     (btn_db)
	);

	sys_control ctrl_i (
		.i_sysclk      (i_sysclk),
		.i_rstn        (i_rstn),
		.i_sof         (sof),
		.i_btn_db      (btn_db),
		.i_sw_gaussian (i_sw_gaussian),
		.i_sw_sobel    (i_sw_sobel),
		.o_cfg_start   (cfg_start),
		.o_pipe_ctrl   (o_pipe_ctrl)
	);

	cam_config cfg_i (
		.i_sysclk    (i_sysclk),
		.i_rstn      (i_rstn),
		.i_cfg_start (cfg_start),
		.o_cfg_wr    (o_cfg_wr),
		.o_cfg       (o_cfg),
		.o_cfg_done  (o_cfg_done)
	);

	frame_sync fsync_i (
		.i_sysclk      (i_sysclk),
		.i_rstn        (i_rstn),
		.i_vsync       (i_vsync),
		.o_sof         (sof),
		.o_frame_count (o_frame_count)
	);

endmodule

/* verification/tb_vision_ctrl.sv */
// Testbench for the camera control front end.
// Drives button, switches and vsync, steps a cycle model once per clock and
// compares every DUT output against it on the falling edge.
`timescale 1ns/100ps

module tb_vision_ctrl
	import vision_ctrl_pkg::*;
;

	localparam int DB_COUNT       = 4;
	localparam int STIM_DLY       = 10;
	localparam int TIMEOUT_CYCLES = 4000;

	logic                   i_sysclk;
	logic                   i_rstn;
	logic                   i_btn_mode;
	logic                   i_sw_gaussian;
	logic                   i_sw_sobel;
	logic                   i_vsync;
	pipe_ctrl_t             o_pipe_ctrl;
	logic                   o_cfg_wr;
	cfg_write_t             o_cfg;
	logic                   o_cfg_done;
	logic [FRAME_CNT_W-1:0] o_frame_count;

	// Cycle model state, all zero is the reset state
	typedef struct packed {
		logic [1:0]             db_sync;
		logic [7:0]             db_cnt;
		logic                   db_out;
		logic [1:0]             btn_dly;
		pipe_ctrl_t             pipe;
		logic [1:0]             sw_q1;
		logic [1:0]             sw_q2;
		logic                   started;
		logic                   cfg_start;
		logic                   busy;
		logic [CFG_IDX_W-1:0]   idx;
		logic                   wr;
		cfg_write_t             cfg;
		logic                   done;
		logic [2:0]             vs_sync;
		logic                   sof;
		logic [FRAME_CNT_W-1:0] fcount;
	} model_t;

	model_t exp_s;
	int     value_errs = 0;
	int     scen_errs  = 0;
	int     wr_count   = 0;
	int     cycle_cnt  = 0;

	vision_ctrl_top #(.DB_COUNT(DB_COUNT)) dut_i (
		.i_sysclk      (i_sysclk),
		.i_rstn        (i_rstn),
		.i_btn_mode    (i_btn_mode),
		.i_sw_gaussian (i_sw_gaussian),
		.i_sw_sobel    (i_sw_sobel),
		.i_vsync       (i_vsync),
		.o_pipe_ctrl   (o_pipe_ctrl),
		.o_cfg_wr      (o_cfg_wr),
		.o_cfg         (o_cfg),
		.o_cfg_done    (o_cfg_done),
		.o_frame_count (o_frame_count)
	);

	initial begin
		i_sysclk = 1'b0;
		forever #50 i_sysclk = ~i_sysclk;
	end

	// ============================================================
	// Reference model
	// ============================================================
	function automatic model_t model_step(model_t s, logic btn, logic sw_g, logic sw_s,
			logic vs);
		model_t n;
		logic   rise;
		logic   vs_rise;
		mode_e  mode_nxt;
		n = s;
		// Debounced level moves after DB_COUNT+1 disagreeing synchronized cycles
		n.db_sync = {s.db_sync[0], btn};
		if (s.db_sync[1] == s.db_out) begin
			n.db_cnt = '0;
		end else if (int'(s.db_cnt) == DB_COUNT) begin
			n.db_cnt = '0;
			n.db_out = s.db_sync[1];
		end else begin
			n.db_cnt = s.db_cnt + 1'b1;
		end
		// Press detection and mode toggle
		n.btn_dly = {s.btn_dly[0], s.db_out};
		rise      = s.btn_dly[0] & ~s.btn_dly[1];
		mode_nxt  = s.pipe.mode;
		if (rise) begin
			mode_nxt = (s.pipe.mode == MODE_FILTER) ? MODE_PASSTHROUGH : MODE_FILTER;
		end
		n.pipe.mode = mode_nxt;
		n.sw_q1     = {sw_g, sw_s};
		n.sw_q2     = s.sw_q1;
		if (mode_nxt == MODE_PASSTHROUGH) begin
			n.pipe.gaussian_en = 1'b0;
			n.pipe.sobel_en    = 1'b0;
			n.pipe.flush       = 1'b0;
		end else begin
			n.pipe.gaussian_en = s.sw_q1[1];
			n.pipe.sobel_en    = s.sw_q1[0];
			if (!s.pipe.flush) begin
				n.pipe.flush = (s.sw_q1 != s.sw_q2);
			end else if (s.sof) begin
				n.pipe.flush = 1'b0;
			end
		end
		// One configuration run per reset
		n.cfg_start = !s.started;
		n.started   = 1'b1;
		if (!s.busy) begin
			if (s.cfg_start) begin
				n.busy = 1'b1;
				n.idx  = '0;
				n.wr   = 1'b1;
				n.done = 1'b0;
				n.cfg  = CFG_ROM[0];
			end
		end else if (s.idx == CFG_IDX_W'(CFG_ROM_DEPTH - 1)) begin
			n.busy = 1'b0;
			n.wr   = 1'b0;
			n.done = 1'b1;
		end else begin
			n.idx = s.idx + 1'b1;
			n.wr  = 1'b1;
			n.cfg = CFG_ROM[n.idx];
		end
		// Start of frame
		n.vs_sync = {s.vs_sync[1:0], vs};
		vs_rise   = s.vs_sync[1] & ~s.vs_sync[2];
		n.sof     = vs_rise;
		if (vs_rise) begin
			n.fcount = s.fcount + 1'b1;
		end
		return n;
	endfunction

	always @(posedge i_sysclk) begin
		if (!i_rstn) begin
			exp_s = '0;
		end else begin
			exp_s = model_step(exp_s, i_btn_mode, i_sw_gaussian, i_sw_sobel, i_vsync);
		end
	end

	// ============================================================
	// Checks
	// ============================================================
	task automatic check_value(input string what, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp) else begin
			$display("FAIL %0t: %s expected %0h got %0h", $time, what, exp, got);
			value_errs++;
		end
	endtask

	task automatic check_scenario(input logic ok, input string msg);
		assert (ok) else begin
			$display("Scenario check failed at %0t: %s", $time, msg);
			scen_errs++;
		end
	endtask

	// Outputs are settled half a cycle after the rising edge
	always @(negedge i_sysclk) begin
		if (i_rstn) begin
			check_value("pipe_ctrl", 16'(o_pipe_ctrl), 16'(exp_s.pipe));
			check_value("cfg_wr", 16'(o_cfg_wr), 16'(exp_s.wr));
			check_value("cfg_done", 16'(o_cfg_done), 16'(exp_s.done));
			check_value("frame_count", o_frame_count, exp_s.fcount);
			if (exp_s.wr) begin
				check_value("cfg write", o_cfg, exp_s.cfg);
			end
			if (o_cfg_wr) begin
				wr_count++;
			end
		end
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge i_sysclk);
			cycle_cnt++;
		end
		$display("Errors: %0d value mismatches, %0d scenario failures", value_errs, scen_errs);
		$display("Timeout: the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic next_cycle();
		@(posedge i_sysclk);
		#STIM_DLY;
	endtask

	task automatic press_button();
		i_btn_mode = 1'b1;
		repeat (DB_COUNT + 10) next_cycle();
		i_btn_mode = 1'b0;
		repeat (DB_COUNT + 10) next_cycle();
	endtask

	// Every high pulse is shorter than the debounce count
	task automatic bounce_button();
		repeat (6) begin
			i_btn_mode = 1'b1;
			repeat ($urandom_range(DB_COUNT - 1, 1)) next_cycle();
			i_btn_mode = 1'b0;
			repeat ($urandom_range(3, 1)) next_cycle();
		end
		repeat (DB_COUNT + 10) next_cycle();
	endtask

	task automatic wait_cfg_done(input int limit);
		int n;
		n = 0;
		while (!o_cfg_done && n < limit) begin
			next_cycle();
			n++;
		end
		check_scenario(o_cfg_done, "camera configuration never signalled done");
	endtask

	task automatic run_random(input int cycles);
		int vs_timer;
		vs_timer = 0;
		repeat (cycles) begin
			if (vs_timer == 0) begin
				i_vsync  = ~i_vsync;
				vs_timer = i_vsync ? $urandom_range(40, 1) : $urandom_range(80, 10);
			end else begin
				vs_timer--;
			end
			if ($urandom_range(49, 0) == 0) i_sw_gaussian = ~i_sw_gaussian;
			if ($urandom_range(49, 0) == 0) i_sw_sobel = ~i_sw_sobel;
			next_cycle();
		end
	endtask

	initial begin
		i_rstn        = 1'b0;
		i_btn_mode    = 1'b0;
		i_sw_gaussian = 1'b0;
		i_sw_sobel    = 1'b0;
		i_vsync       = 1'b0;
		void'($urandom(74));
		repeat (5) @(posedge i_sysclk);
		#STIM_DLY;
		i_rstn = 1'b1;

		wait_cfg_done(50);
		repeat (20) next_cycle();
		check_scenario(wr_count == CFG_ROM_DEPTH, "wrong number of register writes");

		run_random(60);
		// Both switches on while still in passthrough
		i_sw_gaussian = 1'b1;
		i_sw_sobel    = 1'b1;
		bounce_button();
		check_scenario(o_pipe_ctrl.mode == MODE_PASSTHROUGH, "bouncing press toggled mode");
		check_scenario(!o_pipe_ctrl.gaussian_en && !o_pipe_ctrl.sobel_en,
			"filter enable set in passthrough mode");
		press_button();
		check_scenario(o_pipe_ctrl.mode == MODE_FILTER, "clean press did not enter filter");
		run_random(800);

		// Flush raised without a frame start, then dropped by leaving filter mode
		i_vsync = 1'b0;
		repeat (10) next_cycle();
		i_sw_gaussian = ~i_sw_gaussian;
		repeat (4) next_cycle();
		check_scenario(o_pipe_ctrl.flush, "switch change did not raise flush");
		press_button();
		check_scenario(!o_pipe_ctrl.flush, "flush still high in passthrough mode");

		press_button();
		run_random(600);
		check_scenario(wr_count == CFG_ROM_DEPTH, "register write after configuration done");

		$display("Errors: %0d value mismatches, %0d scenario failures", value_errs, scen_errs);
		if (value_errs == 0 && scen_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* filelist.f */
src/vision_ctrl_pkg.sv
src/debounce.sv
src/sys_control.sv
src/cam_config.sv
src/frame_sync.sv
src/vision_ctrl_top.sv
verification/tb_vision_ctrl.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_vision_ctrl
FILELIST = filelist.f
SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir
